// File: sim.f
hw/bus_pkg.sv
hw/cfg_pkg.sv
hw/bus_if.sv
hw/bus_master.sv
hw/bus_arbiter.sv
hw/bus_cfg_regs.sv
hw/mem_slave.sv
hw/bus_top.sv
+incdir+verif
verif/tb_bus_top.sv

// File: Makefile
TOP = tb_bus_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "test failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_bus_ref.svh
// reference memory model, expected read beat, burst length and tie winner functions
`ifndef TB_BUS_REF_SVH
`define TB_BUS_REF_SVH

logic [DATA_W-1:0] ref_mem [MEM_DEPTH];   // words as completed writes left them

// word index of one beat, burst beats step through addr plus beat and wrap
function automatic int unsigned ref_index(input logic [ADDR_W-1:0] addr, input int beat);
   return (int'(addr) + beat) % MEM_DEPTH;
endfunction

// beats that one transaction moves
function automatic int beat_total(input bit burst);
   return burst ? BEATS : 1;
endfunction

// applied when a write's done pulses
function automatic void ref_write(input logic [ADDR_W-1:0] addr,
                                  input logic [BEATS-1:0][DATA_W-1:0] beats,
                                  input bit burst);
   for (int b = 0; b < beat_total(burst); b++) begin
      ref_mem[ref_index(addr, b)] = beats[b];
   end
endfunction

// expected word on a read beat
function automatic logic [DATA_W-1:0] expected_beat(input logic [ADDR_W-1:0] addr,
                                                    input int beat);
   return ref_mem[ref_index(addr, beat)];
endfunction

// fixed priority favours master 0, round-robin skips the last address winner
function automatic bit tie_winner(input bit policy, input bit last_win);
   return policy ? !last_win : 1'b0;
endfunction

`endif

// File: verif/tb_bus_top.sv
// testbench for bus_top: clock, reset, stimulus tasks, compare process and watchdog
`timescale 1ns/1ps

module tb_bus_top import bus_pkg::*, cfg_pkg::*;;
   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 32;
   localparam int MEM_DEPTH  = 256;
   localparam int N_TXN      = 58;                     // transactions issued below
   localparam int WAIT_LIMIT = 4 * (BEATS + 12);       // cycles for one wait, two txns fit
   localparam int WD_CYCLES  = N_TXN * (BEATS + 12) + 400;

   logic clk, rst;
   logic m0_req, m0_write, m0_burst, m1_req, m1_write, m1_burst;
   logic [ADDR_W-1:0] m0_addr, m1_addr;
   logic [BEATS-1:0][DATA_W-1:0] m0_wdata_beats, m1_wdata_beats;
   logic cfg_wr, cfg_rd;
   logic [CFG_AW-1:0] cfg_addr;
   logic [CFG_DW-1:0] cfg_wdata, cfg_rdata;
   logic m0_busy, m0_done, m0_rvalid, m1_busy, m1_done, m1_rvalid;
   logic [DATA_W-1:0] m0_rdata, m1_rdata;

   integer seed = 32'h6c65;
   int errors = 0;
   int checks = 0;
   int done_cnt = 0;                          // completed transactions, both masters
   int done_order [$];                        // master index per done pulse
   bit policy_ref = 1'b0;                     // round-robin when set
   bit last_win_ref = 1'b1;                   // master 0 takes the first tie
   bit exp_first;
   bit cmd_write [2];                         // command in flight per master
   bit cmd_burst [2];
   logic [ADDR_W-1:0] cmd_addr [2];
   logic [BEATS-1:0][DATA_W-1:0] cmd_beats [2];
   int beat_cnt [2];                          // rvalid beats seen

   `include "tb_bus_ref.svh"

   bus_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) bus_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;                 // 100 ns period
   end

   task automatic check(input string name, input logic [DATA_W-1:0] got,
                        input logic [DATA_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // one master per call, rvalid and done never share a cycle
   task automatic observe(input int m, input logic rv, input logic [DATA_W-1:0] rd,
                          input logic dn);
      if (rv) begin
         check($sformatf("m%0d_rdata", m), rd, expected_beat(cmd_addr[m], beat_cnt[m]));
         beat_cnt[m]++;
      end
      if (dn) begin
         if (cmd_write[m]) begin
            ref_write(cmd_addr[m], cmd_beats[m], cmd_burst[m]);
            check($sformatf("m%0d_rvalid on write", m), DATA_W'(beat_cnt[m]), '0);
         end else begin
            check($sformatf("m%0d_rvalid beats", m), DATA_W'(beat_cnt[m]),
                  DATA_W'(beat_total(cmd_burst[m])));
         end
         beat_cnt[m] = 0;
         done_order.push_back(m);
         done_cnt++;
      end
   endtask

   always @(negedge clk) begin                // outputs settled mid cycle
      if (!rst) begin
         observe(0, m0_rvalid, m0_rdata, m0_done);
         observe(1, m1_rvalid, m1_rdata, m1_done);
      end
   end

   initial begin
      #(WD_CYCLES * 100);
      $display("watchdog expired after %0d cycles before all transactions finished",
               WD_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic set_cmd(input int m, input bit write, input bit burst,
                          input logic [ADDR_W-1:0] addr);
      cmd_write[m] = write;
      cmd_burst[m] = burst;
      cmd_addr[m]  = addr;
      for (int b = 0; b < BEATS; b++) cmd_beats[m][b] = $random(seed);
   endtask

   // req pulses for one cycle, expected tie order follows the arbiter rule
   task automatic launch(input bit go0, input bit go1);
      if (go0 && go1) begin
         exp_first    = tie_winner(policy_ref, last_win_ref);
         last_win_ref = !exp_first;           // loser is granted right after
      end else begin
         last_win_ref = go1;
      end
      @(posedge clk);
      m0_req <= go0;
      m0_write <= cmd_write[0];
      m0_burst <= cmd_burst[0];
      m0_addr <= cmd_addr[0];
      m0_wdata_beats <= cmd_beats[0];
      m1_req <= go1;
      m1_write <= cmd_write[1];
      m1_burst <= cmd_burst[1];
      m1_addr <= cmd_addr[1];
      m1_wdata_beats <= cmd_beats[1];
      @(posedge clk);
      m0_req <= 1'b0;
      m1_req <= 1'b0;
   endtask

   task automatic wait_done(input int target);
      int n;
      n = 0;
      while (done_cnt < target && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (done_cnt < target) begin
         errors++;
         $display("%0t: transaction did not finish within %0d cycles", $time, WAIT_LIMIT);
      end
   endtask

   task automatic run_one(input int m, input bit write, input bit burst,
                          input logic [ADDR_W-1:0] addr);
      int target;
      target = done_cnt + 1;
      set_cmd(m, write, burst, addr);
      launch(m == 0, m == 1);
      wait_done(target);
   endtask

   // both masters write in the same cycle, addresses half the memory apart
   task automatic tie_round(output int first);
      logic [ADDR_W-1:0] a;
      int target;
      a = ADDR_W'($random(seed));
      set_cmd(0, 1'b1, 1'b0, a);
      set_cmd(1, 1'b1, 1'b0, a ^ ADDR_W'(MEM_DEPTH / 2));
      target = done_cnt + 2;
      done_order.delete();
      launch(1'b1, 1'b1);
      wait_done(target);
      first = exp_first;
      if (done_order.size() > 0)
         check("first done master", DATA_W'(done_order[0]), DATA_W'(exp_first));
   endtask

   task automatic cfg_write(input logic [CFG_AW-1:0] a, input logic [CFG_DW-1:0] v);
      @(posedge clk);
      cfg_wr <= 1'b1;
      cfg_addr <= a;
      cfg_wdata <= v;
      @(posedge clk);
      cfg_wr <= 1'b0;
      if (a == CFG_POLICY) policy_ref = v[0];
   endtask

   task automatic cfg_read(input logic [CFG_AW-1:0] a, output logic [CFG_DW-1:0] v);
      @(posedge clk);
      cfg_rd <= 1'b1;
      cfg_addr <= a;
      @(posedge clk);
      cfg_rd <= 1'b0;
      @(negedge clk);                         // rdata registered on the edge above
      v = cfg_rdata;
   endtask

   initial begin
      logic [ADDR_W-1:0] a;
      logic [CFG_DW-1:0] v;
      int first;
      int w;
      rst <= 1'b1;
      m0_req <= 1'b0;
      m0_write <= 1'b0;
      m0_burst <= 1'b0;
      m0_addr <= '0;
      m0_wdata_beats <= '0;
      m1_req <= 1'b0;
      m1_write <= 1'b0;
      m1_burst <= 1'b0;
      m1_addr <= '0;
      m1_wdata_beats <= '0;
      cfg_wr <= 1'b0;
      cfg_rd <= 1'b0;
      cfg_addr <= '0;
      cfg_wdata <= '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      repeat (4) begin                        // idle after reset
         @(negedge clk);
         check("m0_busy", DATA_W'(m0_busy), '0);
         check("m1_busy", DATA_W'(m1_busy), '0);
         check("m0_done", DATA_W'(m0_done), '0);
         check("m1_done", DATA_W'(m1_done), '0);
      end
      cfg_read(CFG_POLICY, v);
      check("cfg_rdata policy", DATA_W'(v), '0);
      cfg_read(CFG_WAIT, v);
      check("cfg_rdata wait", DATA_W'(v), '0);
      cfg_read(2'd3, v);                      // unmapped
      check("cfg_rdata unmapped", DATA_W'(v), '0);

      for (int m = 0; m < 2; m++) begin       // single write then read back
         for (int i = 0; i < 3; i++) begin
            a = ADDR_W'($random(seed));
            run_one(m, 1'b1, 1'b0, a);
            run_one(m, 1'b0, 1'b0, a);
         end
      end
      for (int m = 0; m < 2; m++) begin       // burst write then burst read
         a = ADDR_W'($random(seed));
         run_one(m, 1'b1, 1'b1, a);
         run_one(m, 1'b0, 1'b1, a);
      end

      repeat (3) tie_round(first);            // fixed priority
      cfg_write(CFG_POLICY, 8'd1);
      repeat (4) begin                        // round-robin, solo read flips the last winner
         tie_round(first);
         run_one(first, 1'b0, 1'b0, cmd_addr[first]);
      end

      for (int k = 0; k < 3; k++) begin       // wait-state sweep
         w = (k == 0) ? 0 : (k == 1) ? 3 : 7;
         cfg_write(CFG_WAIT, CFG_DW'(w));
         cfg_read(CFG_WAIT, v);
         check("cfg_rdata wait", DATA_W'(v), DATA_W'(w));
         for (int m = 0; m < 2; m++) begin
            a = ADDR_W'($random(seed));
            run_one(m, 1'b1, 1'b1, a);
            run_one(m, 1'b0, 1'b1, a);
            a = ADDR_W'($random(seed));
            run_one(m, 1'b1, 1'b0, a);
            run_one(m, 1'b0, 1'b0, a);
         end
      end
      check("completed transactions", DATA_W'(done_cnt), DATA_W'(N_TXN));

      repeat (2) @(posedge clk);
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: hw/bus_top.sv
// top level: two bus masters, arbiter, config registers, memory slave and bus wiring
`timescale 1ns/1ps

module bus_top import bus_pkg::*, cfg_pkg::*; #(
   parameter int ADDR_W    = 16,
   parameter int DATA_W    = 32,
   parameter int MEM_DEPTH = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         m0_req,
   input  logic                         m0_write,
   input  logic                         m0_burst,
   input  logic [ADDR_W-1:0]            m0_addr,
   input  logic [BEATS-1:0][DATA_W-1:0] m0_wdata_beats,
   input  logic                         m1_req,
   input  logic                         m1_write,
   input  logic                         m1_burst,
   input  logic [ADDR_W-1:0]            m1_addr,
   input  logic [BEATS-1:0][DATA_W-1:0] m1_wdata_beats,
   input  logic                         cfg_wr,
   input  logic                         cfg_rd,
   input  logic [CFG_AW-1:0]            cfg_addr,
   input  logic [CFG_DW-1:0]            cfg_wdata,
   output logic                         m0_busy,
   output logic                         m0_done,
   output logic                         m0_rvalid,
   output logic [DATA_W-1:0]            m0_rdata,
   output logic                         m1_busy,
   output logic                         m1_done,
   output logic                         m1_rvalid,
   output logic [DATA_W-1:0]            m1_rdata,
   output logic [CFG_DW-1:0]            cfg_rdata
);
   cfg_t cfg;
   logic m0_br_n;
   logic m1_br_n;
   logic m0_bg_n;
   logic m1_bg_n;
   logic m0_dbg_n;
   logic m1_dbg_n;

   addr_bus_if #(.ADDR_W(ADDR_W)) abus ();      // shared address bus
   addr_bus_if #(.ADDR_W(ADDR_W)) m0_abus ();   // master 0 drivers
   addr_bus_if #(.ADDR_W(ADDR_W)) m1_abus ();   // master 1 drivers
   data_bus_if #(.DATA_W(DATA_W)) dbus ();
   data_bus_if #(.DATA_W(DATA_W)) m0_dbus ();
   data_bus_if #(.DATA_W(DATA_W)) m1_dbus ();

   // wired-AND of the active-low lines, payload ORed since idle masters drive zero
   assign abus.ts_n      = m0_abus.ts_n & m1_abus.ts_n;
   assign abus.abb_n     = m0_abus.abb_n & m1_abus.abb_n;
   assign abus.tbst_n    = m0_abus.tbst_n & m1_abus.tbst_n;
   assign abus.addr      = m0_abus.addr | m1_abus.addr;
   assign abus.tt        = tt_e'(m0_abus.tt | m1_abus.tt);
   assign m0_abus.aack_n = abus.aack_n;
   assign m1_abus.aack_n = abus.aack_n;
   assign dbus.dbb_n     = m0_dbus.dbb_n & m1_dbus.dbb_n;
   assign dbus.wdata     = m0_dbus.wdata | m1_dbus.wdata;
   assign m0_dbus.rdata  = dbus.rdata;
   assign m1_dbus.rdata  = dbus.rdata;
   assign m0_dbus.ta_n   = dbus.ta_n;
   assign m1_dbus.ta_n   = dbus.ta_n;

   bus_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) m0_inst (
      .clk(clk), .rst(rst), .req(m0_req), .write(m0_write), .burst(m0_burst),
      .addr(m0_addr), .wdata_beats(m0_wdata_beats), .bg_n(m0_bg_n), .dbg_n(m0_dbg_n),
      .br_n(m0_br_n), .busy(m0_busy), .done(m0_done), .rvalid(m0_rvalid),
      .rdata(m0_rdata), .abus(m0_abus), .dbus(m0_dbus)
   );

   bus_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) m1_inst (
      .clk(clk), .rst(rst), .req(m1_req), .write(m1_write), .burst(m1_burst),
      .addr(m1_addr), .wdata_beats(m1_wdata_beats), .bg_n(m1_bg_n), .dbg_n(m1_dbg_n),
      .br_n(m1_br_n), .busy(m1_busy), .done(m1_done), .rvalid(m1_rvalid),
      .rdata(m1_rdata), .abus(m1_abus), .dbus(m1_dbus)
   );

   bus_arbiter arb_inst (
      .clk(clk), .rst(rst), .m0_br_n(m0_br_n), .m1_br_n(m1_br_n),
      .policy(cfg.policy), .m0_bg_n(m0_bg_n), .m1_bg_n(m1_bg_n),
      .m0_dbg_n(m0_dbg_n), .m1_dbg_n(m1_dbg_n), .abus(abus)
   );

   bus_cfg_regs cfg_inst (
      .clk(clk), .rst(rst), .cfg_wr(cfg_wr), .cfg_rd(cfg_rd), .cfg_addr(cfg_addr),
      .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .cfg(cfg)
   );

   mem_slave #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) mem_inst (
      .clk(clk), .rst(rst), .wait_cnt(cfg.wait_cnt), .abus(abus), .dbus(dbus)
   );

endmodule

// File: hw/mem_slave.sv
// memory slave: address capture, wait-state aack_n and beat-by-beat ta_n
`timescale 1ns/1ps

module mem_slave import bus_pkg::*; #(
   parameter int ADDR_W    = 16,
   parameter int DATA_W    = 32,
   parameter int MEM_DEPTH = 256
) (
   input  logic       clk,
   input  logic       rst,
   input  logic [2:0] wait_cnt,     // wait states before aack_n
   addr_bus_if.slave  abus,
   data_bus_if.slave  dbus
);
   localparam int IDX_W = $clog2(MEM_DEPTH);

   typedef enum logic [1:0] {M_IDLE, M_WAIT, M_DATA} state_e;

   state_e            state;
   logic [2:0]        cnt;          // wait states left
   logic [BEAT_W-1:0] beat;
   logic [ADDR_W-1:0] a_q;          // captured start address
   tt_e               tt_q;
   logic              burst_q;
   logic [IDX_W-1:0]  idx;          // word of the current beat
   logic [DATA_W-1:0] mem [MEM_DEPTH];

   // burst beats walk addr plus beat, wrapping inside the array
   assign idx = IDX_W'((a_q + ADDR_W'(beat)) % MEM_DEPTH);

   assign abus.aack_n = !(state == M_WAIT && cnt == '0);   // wait_cnt+1 after ts_n
   assign dbus.ta_n   = !(state == M_DATA);
   assign dbus.rdata  = mem[idx];

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= M_IDLE;
         cnt   <= '0;
         beat  <= '0;
      end else begin
         case (state)
            M_IDLE: if (!abus.ts_n) begin
               state <= M_WAIT;
               cnt   <= wait_cnt;
               beat  <= '0;
            end
            M_WAIT: begin
               if (cnt == '0) begin
                  state <= M_DATA;             // first ta_n right after aack_n
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            M_DATA: begin
               if (!burst_q || beat == BEAT_W'(BEATS - 1)) begin
                  state <= M_IDLE;
               end else begin
                  beat <= beat + 1'b1;
               end
            end
            default: state <= M_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == M_IDLE && !abus.ts_n) begin
         a_q     <= abus.addr;
         tt_q    <= abus.tt;
         burst_q <= !abus.tbst_n;
      end
      if (state == M_DATA && tt_q == TT_WRITE && !dbus.dbb_n) begin
         mem[idx] <= dbus.wdata;               // owning master qualifies the beat
      end
   end

   // a data tenure opens only right behind the address acknowledge
   a_ta_after_aack: assert property (@(posedge clk) disable iff (rst)
      $fell(dbus.ta_n) |-> $past(!abus.aack_n));

endmodule

// File: hw/bus_cfg_regs.sv
// configuration registers for arbiter policy and memory wait states
`timescale 1ns/1ps

module bus_cfg_regs import cfg_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              cfg_wr,
   input  logic              cfg_rd,
   input  logic [CFG_AW-1:0] cfg_addr,
   input  logic [CFG_DW-1:0] cfg_wdata,
   output logic [CFG_DW-1:0] cfg_rdata,   // valid the cycle after cfg_rd
   output cfg_t              cfg
);
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg.policy   <= 1'b0;              // fixed priority
         cfg.wait_cnt <= 3'd0;              // no wait states
         cfg_rdata    <= '0;
      end else begin
         if (cfg_wr) begin
            case (cfg_addr)
               CFG_POLICY: cfg.policy   <= cfg_wdata[0];
               CFG_WAIT:   cfg.wait_cnt <= cfg_wdata[2:0];
               default:    ;                // unmapped write dropped
            endcase
         end
         if (cfg_rd) begin
            case (cfg_addr)
               CFG_POLICY: cfg_rdata <= CFG_DW'(cfg.policy);
               CFG_WAIT:   cfg_rdata <= CFG_DW'(cfg.wait_cnt);
               default:    cfg_rdata <= '0;
            endcase
         end
      end
   end

endmodule

// File: hw/bus_arbiter.sv
// address and data bus arbiter with fixed-priority and round-robin policies
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       m0_br_n,
   input  logic       m1_br_n,
   input  logic       policy,      // round-robin when set
   output logic       m0_bg_n,
   output logic       m1_bg_n,
   output logic       m0_dbg_n,
   output logic       m1_dbg_n,
   addr_bus_if.arbiter abus
);
   logic              a_busy;      // address grant outstanding
   logic              a_own;       // address owner, 1 is master 1
   logic              d_busy;      // data tenure open
   logic              d_own;       // data owner
   logic              last_win;    // previous address winner
   logic              burst_q;     // tbst_n taken with ts_n
   logic [BEAT_W-1:0] d_left;      // beats after the current one
   logic              pick;        // winner among the requests

   // both requesting: fixed gives master 0, round-robin gives the other one
   assign pick = (!m0_br_n && !m1_br_n) ? (policy && !last_win) : m0_br_n;

   assign m0_bg_n  = !(a_busy && !a_own);
   assign m1_bg_n  = !(a_busy && a_own);
   assign m0_dbg_n = !(d_busy && !d_own);
   assign m1_dbg_n = !(d_busy && d_own);

   always_ff @(posedge clk) begin
      if (rst) begin
         a_busy   <= 1'b0;
         a_own    <= 1'b0;
         d_busy   <= 1'b0;
         d_own    <= 1'b0;
         last_win <= 1'b1;         // master 0 wins the first round-robin tie
         burst_q  <= 1'b0;
         d_left   <= '0;
      end else begin
         if (!a_busy && !d_busy && abus.abb_n && !(m0_br_n && m1_br_n)) begin
            a_busy   <= 1'b1;      // bg_n low one cycle after br_n
            a_own    <= pick;
            last_win <= pick;
         end
         if (!abus.ts_n) begin
            burst_q <= !abus.tbst_n;
         end
         if (a_busy && !abus.aack_n) begin
            a_busy <= 1'b0;        // address bus free, data bus to the same owner
            d_busy <= 1'b1;
            d_own  <= a_own;
            d_left <= burst_q ? BEAT_W'(BEATS - 1) : '0;
         end else if (d_busy) begin
            if (d_left == '0) begin
               d_busy <= 1'b0;     // final ta_n of the tenure
            end else begin
               d_left <= d_left - 1'b1;
            end
         end
      end
   end

   // address grant only goes to a requesting master
   a_grant_req0: assert property (@(posedge clk) disable iff (rst)
      $fell(m0_bg_n) |-> $past(!m0_br_n));
   a_grant_req1: assert property (@(posedge clk) disable iff (rst)
      $fell(m1_bg_n) |-> $past(!m1_br_n));
   // data grant follows the address owner
   a_data_owner0: assert property (@(posedge clk) disable iff (rst)
      $fell(m0_dbg_n) |-> $past(!m0_bg_n));
   a_data_owner1: assert property (@(posedge clk) disable iff (rst)
      $fell(m1_dbg_n) |-> $past(!m1_bg_n));

endmodule

// File: hw/bus_master.sv
// bus master: command capture, bus request, address tenure and data tenure FSM
`timescale 1ns/1ps

module bus_master import bus_pkg::*; #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         req,           // command strobe, dropped when busy
   input  logic                         write,
   input  logic                         burst,
   input  logic [ADDR_W-1:0]            addr,
   input  logic [BEATS-1:0][DATA_W-1:0] wdata_beats,
   input  logic                         bg_n,          // address bus grant
   input  logic                         dbg_n,         // data bus grant
   output logic                         br_n,          // address bus request
   output logic                         busy,
   output logic                         done,
   output logic                         rvalid,
   output logic [DATA_W-1:0]            rdata,
   addr_bus_if.master                   abus,
   data_bus_if.master                   dbus
);
   typedef enum logic [2:0] {S_IDLE, S_REQ, S_ADDR, S_DWAIT, S_DATA} state_e;

   state_e                       state;
   logic                         c_write;    // latched command
   logic                         c_burst;
   logic [ADDR_W-1:0]            c_addr;
   logic [BEATS-1:0][DATA_W-1:0] c_wdata;
   logic [BEAT_W-1:0]            beat;       // data beat in flight
   logic                         a_own;      // in address tenure under our grant
   logic                         d_own;      // in data tenure under our grant
   logic                         last_beat;

   assign a_own     = !bg_n && (state == S_ADDR || state == S_DWAIT);
   assign d_own     = !dbg_n && (state == S_DATA);
   assign last_beat = !c_burst || (beat == BEAT_W'(BEATS - 1));

   assign br_n   = (state != S_REQ);                  // held until bg_n seen
   assign busy   = (state != S_IDLE);
   assign rvalid = d_own && !dbus.ta_n && !c_write;   // one pulse per read beat
   assign rdata  = dbus.rdata;

   // lines stay inactive without the grant so the top can AND them
   assign abus.ts_n   = !(a_own && state == S_ADDR);
   assign abus.abb_n  = !a_own;                       // released after aack_n
   assign abus.tbst_n = !(a_own && c_burst);
   assign abus.addr   = a_own ? c_addr : '0;
   assign abus.tt     = (a_own && c_write) ? TT_WRITE : TT_READ;
   assign dbus.dbb_n  = !d_own;
   assign dbus.wdata  = (d_own && c_write) ? c_wdata[beat] : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         beat  <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            S_IDLE: if (req) begin
               state <= S_REQ;
               beat  <= '0;
            end
            S_REQ: if (!bg_n) begin
               state <= S_ADDR;                       // ts_n in the next cycle
            end
            S_ADDR: state <= S_DWAIT;                 // ts_n is low for this cycle only
            S_DWAIT: if (!abus.aack_n) begin
               state <= S_DATA;                       // first ta_n comes next
            end
            S_DATA: if (d_own && !dbus.ta_n) begin
               if (last_beat) begin
                  state <= S_IDLE;
                  done  <= 1'b1;                      // cycle after the last ta_n
               end else begin
                  beat <= beat + 1'b1;                // next word on the next ta_n
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && req) begin
         c_write <= write;
         c_burst <= burst;
         c_addr  <= addr;
         c_wdata <= wdata_beats;
      end
   end

   // address tenure never runs without the address grant
   a_ts_grant: assert property (@(posedge clk) disable iff (rst)
      (state == S_ADDR || state == S_DWAIT) |-> !bg_n);
   a_dbb_grant: assert property (@(posedge clk) disable iff (rst)
      state == S_DATA |-> !dbg_n);

endmodule

// File: hw/bus_if.sv
// address bus and data bus interfaces with master, arbiter and slave modports
`timescale 1ns/1ps

interface addr_bus_if import bus_pkg::*; #(
   parameter int ADDR_W = 16
) ();
   logic              ts_n;     // transfer start, one cycle
   logic [ADDR_W-1:0] addr;     // word address
   tt_e               tt;       // read or write
   logic              tbst_n;   // burst of BEATS when low
   logic              abb_n;    // address bus busy
   logic              aack_n;   // address acknowledge from the slave

   modport master (
      output ts_n, addr, tt, tbst_n, abb_n,
      input  aack_n
   );
   modport arbiter (
      input ts_n, tbst_n, abb_n, aack_n
   );
   modport slave (
      input  ts_n, addr, tt, tbst_n,
      output aack_n
   );
endinterface

interface data_bus_if #(
   parameter int DATA_W = 32
) ();
   logic [DATA_W-1:0] wdata;    // write beat from the owning master
   logic              dbb_n;    // data bus busy
   logic [DATA_W-1:0] rdata;    // read beat from the slave
   logic              ta_n;     // transfer acknowledge, one per beat

   modport master (output wdata, dbb_n, input rdata, ta_n);
   modport slave  (input wdata, dbb_n, output rdata, ta_n);
endinterface

// File: hw/cfg_pkg.sv
// configuration constants: register port widths, register map and config struct
package cfg_pkg;

   localparam int CFG_AW = 2;   // register address width
   localparam int CFG_DW = 8;   // register data width

   typedef enum logic [CFG_AW-1:0] {
      CFG_POLICY = 2'd0,        // bit 0 set selects round-robin
      CFG_WAIT   = 2'd1         // bits 2..0 hold address wait states
   } cfg_addr_e;

   typedef struct packed {
      logic       policy;       // arbiter policy, 0 is fixed priority
      logic [2:0] wait_cnt;     // memory wait states before aack_n
   } cfg_t;

endpackage

// File: hw/bus_pkg.sv
// bus constants: burst beat count, beat index width and transfer type enumeration
package bus_pkg;

   localparam int BEATS  = 4;               // beats in a burst tenure
   localparam int BEAT_W = $clog2(BEATS);   // width of a beat index

   // read encodes as zero so an idle master ORs nothing onto tt
   typedef enum logic {
      TT_READ  = 1'b0,
      TT_WRITE = 1'b1
   } tt_e;

endpackage
